// File: verilog/video_pkg.sv
// source video stream geometry and pixel format
// shared by the sync front end, the decimator and the frame buffer
package video_pkg;

    // pixel format
    localparam int RGB_W    = 24;     // packed {r, g, b}, 8 bits each

    // decimation ratios
    localparam int H_DECIM  = 4;      // keep 1 of 4 pixels in a line
    localparam int V_DECIM  = 4;      // keep 1 of 4 lines in a frame

    // phase counter widths follow the ratios
    localparam int HPH_W    = $clog2(H_DECIM);
    localparam int VPH_W    = $clog2(V_DECIM);

    // active source area
    localparam int SRC_COLS = 128;    // de pixels per line
    localparam int SRC_ROWS = 72;     // active lines per frame

    // width of column / line counters
    // also wide enough for the decimated output counts
    localparam int COL_W    = 8;

endpackage

// File: verilog/capture_pkg.sv
// frame buffer geometry, frame skip ratio and capture FSM encoding
package capture_pkg;

    // stored image, after decimation
    localparam int OUT_COLS  = 32;                  // kept pixels per line
    localparam int OUT_ROWS  = 18;                  // kept lines per frame

    // buffer size in words, raster order
    localparam int FB_DEPTH  = OUT_COLS * OUT_ROWS; // 576
    localparam int FB_ADDR_W = 10;

    // capture one frame, then skip F_SKIP-1 frames
    localparam int F_SKIP    = 3;
    localparam int FRM_W     = $clog2(F_SKIP);

    // capture FSM
    typedef enum logic [1:0] {
        CAP_WAIT   = 2'd0,  // no frame start seen since reset
        CAP_ACTIVE = 2'd1,  // current frame goes into the buffer
        CAP_SKIP   = 2'd2   // current frame is dropped
    } capture_state_e;

endpackage

// File: verilog/sync_edge_detect.sv
`timescale 1ns/1ps

// input stage for the video stream
// registers de and pixel and turns the active-low syncs into
// one-cycle pulses on their assertion edge
// only block that knows about sync polarity
module sync_edge_detect
    import video_pkg::*;
(
    input  logic             i_Clk,
    input  logic             i_reset,
    input  logic             i_hsync_n,    // active low
    input  logic             i_vsync_n,    // active low
    input  logic             i_vde,
    input  logic [RGB_W-1:0] i_rgb,
    output logic             o_de,
    output logic [RGB_W-1:0] o_rgb,
    output logic             o_line_start, // hsync assertion
    output logic             o_frame_start // vsync assertion
);

    logic hsync_act;   // positive polarity syncs
    logic vsync_act;
    logic hsync_prev;  // sync level seen last edge
    logic vsync_prev;

    assign hsync_act = ~i_hsync_n;
    assign vsync_act = ~i_vsync_n;

    // control path
    always_ff @(posedge i_Clk) begin
        if (i_reset) begin
            hsync_prev    <= 1'b0;
            vsync_prev    <= 1'b0;
            o_de          <= 1'b0;
            o_line_start  <= 1'b0;
            o_frame_start <= 1'b0;
        end else begin
            hsync_prev    <= hsync_act;
            vsync_prev    <= vsync_act;
            o_de          <= i_vde;                    // same delay as pixel
            o_line_start  <= hsync_act & ~hsync_prev;  // rising edge only
            o_frame_start <= vsync_act & ~vsync_prev;
        end
    end

    // pixel payload qualified downstream by o_de
    always_ff @(posedge i_Clk) begin
        o_rgb <= i_rgb;
    end

endmodule

// File: verilog/pixel_decimator.sv
`timescale 1ns/1ps

// keeps 1 of H_DECIM pixels per line, 1 of V_DECIM lines per frame
// and 1 of F_SKIP frames
// kept pixels become frame buffer writes in raster order
module pixel_decimator
    import video_pkg::*;
    import capture_pkg::*;
(
    input  logic                 i_Clk,
    input  logic                 i_reset,
    input  logic                 i_de,
    input  logic [RGB_W-1:0]     i_rgb,
    input  logic                 i_line_start,
    input  logic                 i_frame_start,
    output logic                 o_wr_en,
    output logic [FB_ADDR_W-1:0] o_wr_addr,
    output logic [RGB_W-1:0]     o_wr_data,
    output logic                 o_frame_start, // kept frames only
    output logic                 o_frame_done,  // last word written
    output logic                 o_capturing
);

    capture_state_e       state;
    logic [FRM_W-1:0]     frame_cnt;    // mod F_SKIP, 0 means capture
    logic [HPH_W-1:0]     pix_phase;    // mod H_DECIM
    logic [VPH_W-1:0]     line_phase;   // mod V_DECIM
    logic [COL_W-1:0]     out_col;      // saturates at OUT_COLS
    logic [COL_W-1:0]     out_row;      // saturates at OUT_ROWS
    logic                 line_active;  // current line has phase 0
    logic [FB_ADDR_W-1:0] addr_cnt;     // next write address

    logic                 keep_frame;
    logic [FRM_W-1:0]     frame_cnt_nxt;
    logic [HPH_W-1:0]     pix_phase_nxt;
    logic [VPH_W-1:0]     line_phase_nxt;
    logic [COL_W-1:0]     out_row_nxt;
    logic                 keep_pix;
    logic                 last_word;

    always_comb begin
        keep_frame     = (frame_cnt == '0);
        frame_cnt_nxt  = (frame_cnt == FRM_W'(F_SKIP - 1)) ? '0 : frame_cnt + 1'b1;
        pix_phase_nxt  = (pix_phase == HPH_W'(H_DECIM - 1)) ? '0 : pix_phase + 1'b1;
        line_phase_nxt = (line_phase == VPH_W'(V_DECIM - 1)) ? '0 : line_phase + 1'b1;

        // a kept line that ends moves the row on, stuck at OUT_ROWS
        if (line_active && (out_row < COL_W'(OUT_ROWS)))
            out_row_nxt = out_row + 1'b1;
        else
            out_row_nxt = out_row;

        // sync pulses never carry a pixel
        keep_pix = (state == CAP_ACTIVE) && i_de
                   && !i_frame_start && !i_line_start
                   && (pix_phase == '0) && line_active
                   && (out_col < COL_W'(OUT_COLS))
                   && (out_row < COL_W'(OUT_ROWS));

        last_word = (addr_cnt == FB_ADDR_W'(FB_DEPTH - 1));
    end

    // capture FSM and counters
    always_ff @(posedge i_Clk) begin
        if (i_reset) begin
            state         <= CAP_WAIT;
            frame_cnt     <= '0;       // first frame after reset is kept
            pix_phase     <= '0;
            line_phase    <= '0;
            out_col       <= '0;
            out_row       <= '0;
            line_active   <= 1'b0;
            addr_cnt      <= '0;
            o_wr_en       <= 1'b0;
            o_frame_start <= 1'b0;
            o_frame_done  <= 1'b0;
        end else begin
            o_wr_en       <= keep_pix;
            o_frame_done  <= keep_pix && last_word;
            o_frame_start <= i_frame_start && keep_frame;

            if (i_frame_start) begin
                state     <= keep_frame ? CAP_ACTIVE : CAP_SKIP;
                frame_cnt <= frame_cnt_nxt;
                out_col   <= '0;
                out_row   <= '0;
                addr_cnt  <= '0;   // an unfinished frame is simply abandoned
                pix_phase <= '0;
                // first line_start after this lands on phase 0
                // unless hsync comes in the same cycle
                line_phase  <= i_line_start ? '0 : VPH_W'(V_DECIM - 1);
                line_active <= i_line_start;
            end else if (i_line_start) begin
                pix_phase   <= '0;
                line_phase  <= line_phase_nxt;
                line_active <= (line_phase_nxt == '0);
                out_col     <= '0;
                out_row     <= out_row_nxt;
            end else if (i_de) begin
                pix_phase <= pix_phase_nxt;  // counts de pixels only
                if (keep_pix) begin
                    out_col  <= out_col + 1'b1;
                    addr_cnt <= addr_cnt + 1'b1;
                end
            end
        end
    end

    // write payload, valid with o_wr_en
    always_ff @(posedge i_Clk) begin
        if (keep_pix) begin
            o_wr_addr <= addr_cnt;
            o_wr_data <= i_rgb;
        end
    end

    assign o_capturing = (state == CAP_ACTIVE);

endmodule

// File: verilog/frame_buffer.sv
`timescale 1ns/1ps

// simple dual port RAM holding one decimated frame
// one write port, one registered read port
module frame_buffer
    import video_pkg::*;
    import capture_pkg::*;
(
    input  logic                 i_Clk,
    input  logic                 i_reset,
    input  logic                 i_wr_en,
    input  logic [FB_ADDR_W-1:0] i_wr_addr,
    input  logic [RGB_W-1:0]     i_wr_data,
    input  logic                 i_rd_en,
    input  logic [FB_ADDR_W-1:0] i_rd_addr,
    output logic [RGB_W-1:0]     o_rd_data,
    output logic                 o_rd_valid    // i_rd_en delayed 1
);

    logic [RGB_W-1:0] mem [FB_DEPTH];  // block RAM

    // write and read share one process
    // a read of the word being written returns the old value
    always_ff @(posedge i_Clk) begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_data;
        if (i_rd_en)
            o_rd_data <= mem[i_rd_addr];  // registered output
    end

    // read strobe tracking
    always_ff @(posedge i_Clk) begin
        if (i_reset)
            o_rd_valid <= 1'b0;
        else
            o_rd_valid <= i_rd_en;
    end

endmodule

// File: verilog/frame_capture_top.sv
`timescale 1ns/1ps

// frame capture subsystem
// sync front end -> decimator -> frame buffer
// single pixel clock, no flow control
module frame_capture_top
    import video_pkg::*;
    import capture_pkg::*;
(
    input  logic                 i_Clk,
    input  logic                 i_reset,
    // source stream
    input  logic                 i_hsync_n,
    input  logic                 i_vsync_n,
    input  logic                 i_vde,
    input  logic [RGB_W-1:0]     i_rgb,
    // consumer read port
    input  logic                 i_rd_en,
    input  logic [FB_ADDR_W-1:0] i_rd_addr,
    output logic [RGB_W-1:0]     o_rd_data,
    output logic                 o_rd_valid,
    // status
    output logic                 o_frame_start,
    output logic                 o_frame_done,
    output logic                 o_capturing
);

    // front end to decimator
    logic                 vid_de;
    logic [RGB_W-1:0]     vid_rgb;
    logic                 line_start;
    logic                 frame_start;

    // decimator to buffer
    logic                 wr_en;
    logic [FB_ADDR_W-1:0] wr_addr;
    logic [RGB_W-1:0]     wr_data;

    sync_edge_detect sync_edge_detect_i (
        .i_Clk         (i_Clk),
        .i_reset       (i_reset),
        .i_hsync_n     (i_hsync_n),
        .i_vsync_n     (i_vsync_n),
        .i_vde         (i_vde),
        .i_rgb         (i_rgb),
        .o_de          (vid_de),
        .o_rgb         (vid_rgb),
        .o_line_start  (line_start),
        .o_frame_start (frame_start)
    );

    pixel_decimator pixel_decimator_i (
        .i_Clk         (i_Clk),
        .i_reset       (i_reset),
        .i_de          (vid_de),
        .i_rgb         (vid_rgb),
        .i_line_start  (line_start),
        .i_frame_start (frame_start),
        .o_wr_en       (wr_en),
        .o_wr_addr     (wr_addr),
        .o_wr_data     (wr_data),
        .o_frame_start (o_frame_start),  // 2 cycles after vsync edge
        .o_frame_done  (o_frame_done),   // with last buffer write
        .o_capturing   (o_capturing)
    );

    frame_buffer frame_buffer_i (
        .i_Clk         (i_Clk),
        .i_reset       (i_reset),
        .i_wr_en       (wr_en),
        .i_wr_addr     (wr_addr),
        .i_wr_data     (wr_data),
        .i_rd_en       (i_rd_en),
        .i_rd_addr     (i_rd_addr),
        .o_rd_data     (o_rd_data),
        .o_rd_valid    (o_rd_valid)
    );

endmodule

// File: verif/frame_capture_sva.sv
`timescale 1ns/1ps

// write side checks on the pixel decimator
module frame_capture_sva
    import capture_pkg::*;
(
    input logic                 i_Clk,
    input logic                 i_reset,
    input logic                 i_wr_en,
    input logic [FB_ADDR_W-1:0] i_wr_addr,
    input logic                 i_frame_done,
    input logic                 i_capturing
);

    // never write past the buffer
    a_wr_addr_range: assert property (@(posedge i_Clk) disable iff (i_reset)
        i_wr_en |-> (i_wr_addr < FB_ADDR_W'(FB_DEPTH)))
        else $error("write address 0x%0h beyond buffer", i_wr_addr);

    // done only together with the last word
    a_done_last: assert property (@(posedge i_Clk) disable iff (i_reset)
        i_frame_done |-> (i_wr_en && (i_wr_addr == FB_ADDR_W'(FB_DEPTH - 1))))
        else $error("frame done without write of last address");

    // skipped frames stay out of the buffer
    a_wr_capturing: assert property (@(posedge i_Clk) disable iff (i_reset)
        i_wr_en |-> i_capturing)
        else $error("buffer write outside an active capture");

endmodule

bind pixel_decimator frame_capture_sva frame_capture_sva_i (
    .i_Clk        (i_Clk),
    .i_reset      (i_reset),
    .i_wr_en      (o_wr_en),
    .i_wr_addr    (o_wr_addr),
    .i_frame_done (o_frame_done),
    .i_capturing  (o_capturing)
);

// File: verif/frame_capture_tb.sv
`timescale 1ns/1ps

// directed testbench for the frame capture subsystem
// drives a small raster stream and reads back the frame buffer
module frame_capture_tb
    import video_pkg::*;
    import capture_pkg::*;
();

    localparam logic [31:0] SEED = 32'hc447_0e33;
    localparam int FLD_W    = RGB_W / 3;        // tag, line and column fields
    localparam int RST_CYC  = 10;
    localparam int VS_CYC   = 4;                // vsync pulse width
    localparam int HS_CYC   = 2;                // hsync pulse width
    localparam int BP_CYC   = 6;                // back porch
    localparam int FP_CYC   = 5;                // front porch
    localparam int TAIL_CYC = 8;                // idle after last line
    localparam int LINE_MAX = HS_CYC + BP_CYC + SRC_COLS + 16 + FP_CYC;
    localparam int FRAME_MAX = VS_CYC + BP_CYC + (SRC_ROWS + 8) * LINE_MAX + TAIL_CYC;
    localparam int N_FRAMES = 13;
    localparam int N_READS  = 6;
    localparam int TIMEOUT_CYC =
        2 * (RST_CYC + N_FRAMES * FRAME_MAX + N_READS * (FB_DEPTH + 4));

    logic                 i_Clk = 1'b0;
    logic                 i_reset;
    logic                 i_hsync_n;
    logic                 i_vsync_n;
    logic                 i_vde;
    logic [RGB_W-1:0]     i_rgb;
    logic                 i_rd_en;
    logic [FB_ADDR_W-1:0] i_rd_addr;
    logic [RGB_W-1:0]     o_rd_data;
    logic                 o_rd_valid;
    logic                 o_frame_start;
    logic                 o_frame_done;
    logic                 o_capturing;

    logic [31:0] lfsr_state = SEED;
    int          cycle_cnt = 0;
    int          start_cnt = 0;   // pulses seen since last clear
    int          done_cnt = 0;
    int          write_cnt = 0;

    frame_capture_top frame_capture_top_i (
        .i_Clk         (i_Clk),
        .i_reset       (i_reset),
        .i_hsync_n     (i_hsync_n),
        .i_vsync_n     (i_vsync_n),
        .i_vde         (i_vde),
        .i_rgb         (i_rgb),
        .i_rd_en       (i_rd_en),
        .i_rd_addr     (i_rd_addr),
        .o_rd_data     (o_rd_data),
        .o_rd_valid    (o_rd_valid),
        .o_frame_start (o_frame_start),
        .o_frame_done  (o_frame_done),
        .o_capturing   (o_capturing)
    );

    always #4 i_Clk = ~i_Clk;  // 8 ns period

    // pulse and write counters sampled mid cycle
    always @(negedge i_Clk) begin
        if (!i_reset) begin
            if (o_frame_start)
                start_cnt++;
            if (o_frame_done)
                done_cnt++;
            if (frame_capture_top_i.wr_en)
                write_cnt++;
        end
    end

    // watchdog
    always @(posedge i_Clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles, test sequence never finished", cycle_cnt);
            $display("Regression failed");
            $fatal(1, "watchdog expired");
        end
    end

    // Galois LFSR stepped once per bit handed out
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [RGB_W-1:0] garbage_rgb();
        logic [RGB_W-1:0] v;
        for (int i = 0; i < RGB_W; i++)
            v[i] = lfsr_bit();
        return v;
    endfunction

    function automatic logic [RGB_W-1:0] make_pixel(int tag, int y, int x);
        return {FLD_W'(tag), FLD_W'(y), FLD_W'(x)};
    endfunction

    // stored word a came from column (a mod OUT_COLS)*H_DECIM
    // and line (a div OUT_COLS)*V_DECIM
    function automatic logic [RGB_W-1:0] expected_word(int tag, int a);
        return make_pixel(tag, (a / OUT_COLS) * V_DECIM, (a % OUT_COLS) * H_DECIM);
    endfunction

    task automatic check_pixel(string name, logic [RGB_W-1:0] got, logic [RGB_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%06h expected 0x%06h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic tick();
        @(posedge i_Clk);
        #1;  // drive just after the edge
    endtask

    task automatic clear_counts();
        start_cnt = 0;
        done_cnt = 0;
        write_cnt = 0;
    endtask

    task automatic expect_counts(int starts, int dones, int writes);
        check_count("o_frame_start pulses", start_cnt, starts);
        check_count("o_frame_done pulses", done_cnt, dones);
        check_count("wr_en writes", write_cnt, writes);
    endtask

    // blanking cycles with given sync levels and junk on the pixel bus
    task automatic drive_idle(int n, logic hs_n, logic vs_n);
        repeat (n) begin
            tick();
            i_hsync_n = hs_n;
            i_vsync_n = vs_n;
            i_vde = 1'b0;
            i_rgb = garbage_rgb();
        end
    endtask

    task automatic send_frame(int tag, int extra_cols, int extra_lines, int cut_line);
        int n_lines;
        n_lines = (cut_line != 0) ? cut_line : SRC_ROWS + extra_lines;
        drive_idle(VS_CYC, 1'b1, 1'b0);
        drive_idle(BP_CYC, 1'b1, 1'b1);
        for (int y = 0; y < n_lines; y++) begin
            drive_idle(HS_CYC, 1'b0, 1'b1);
            drive_idle(BP_CYC, 1'b1, 1'b1);
            for (int x = 0; x < SRC_COLS + extra_cols; x++) begin
                tick();
                i_vde = 1'b1;
                i_rgb = make_pixel(tag, y, x);
            end
            drive_idle(FP_CYC, 1'b1, 1'b1);
        end
        drive_idle(TAIL_CYC, 1'b1, 1'b1);
    endtask

    // frames in the skip window leave the buffer alone
    task automatic skip_frames(int first_tag, int n);
        clear_counts();
        for (int f = 0; f < n; f++) begin
            send_frame(first_tag + f, 0, 0, 0);
            check_flag("o_capturing", o_capturing, 1'b0);
        end
        expect_counts(0, 0, 0);
    endtask

    // words below split carry new_tag and the rest old_tag
    task automatic read_frame(int new_tag, int old_tag, int split);
        logic [RGB_W-1:0] exp;
        int               tag;
        check_flag("o_rd_valid", o_rd_valid, 1'b0);
        for (int a = 0; a <= FB_DEPTH; a++) begin
            tick();
            if (a > 0) begin
                tag = (a - 1 < split) ? new_tag : old_tag;
                exp = expected_word(tag, a - 1);
                check_flag("o_rd_valid", o_rd_valid, 1'b1);
                check_pixel($sformatf("o_rd_data[0x%0h]", a - 1), o_rd_data, exp);
            end
            i_rd_en = (a < FB_DEPTH);
            i_rd_addr = FB_ADDR_W'(a % FB_DEPTH);
        end
        tick();
        check_flag("o_rd_valid", o_rd_valid, 1'b0);  // one cycle after last read
    endtask

    task automatic check_quiet_outputs();
        check_flag("o_frame_start", o_frame_start, 1'b0);
        check_flag("o_frame_done", o_frame_done, 1'b0);
        check_flag("o_rd_valid", o_rd_valid, 1'b0);
        check_flag("o_capturing", o_capturing, 1'b0);
    endtask

    task automatic test_reset();
        i_reset = 1'b1;
        repeat (RST_CYC) begin
            tick();
            check_quiet_outputs();
        end
        i_reset = 1'b0;
        repeat (3) begin
            tick();
            check_quiet_outputs();
        end
    endtask

    task automatic test_capture();
        clear_counts();
        send_frame(1, 0, 0, 0);
        expect_counts(1, 1, FB_DEPTH);
        check_flag("o_capturing", o_capturing, 1'b1);
        read_frame(1, 1, FB_DEPTH);
    endtask

    task automatic test_skip();
        skip_frames(2, 2);
        read_frame(1, 1, FB_DEPTH);  // still frame 1
        clear_counts();
        send_frame(4, 0, 0, 0);
        expect_counts(1, 1, FB_DEPTH);
        read_frame(4, 4, FB_DEPTH);
    endtask

    task automatic test_overflow();
        skip_frames(5, 2);
        clear_counts();
        send_frame(7, 9, 6, 0);      // wide lines and extra rows
        expect_counts(1, 1, FB_DEPTH);
        read_frame(7, 7, FB_DEPTH);
    endtask

    task automatic test_early_vsync();
        skip_frames(8, 2);
        clear_counts();
        send_frame(10, 0, 0, 20);    // kept lines 0,4,8,12,16 only
        expect_counts(1, 0, 5 * OUT_COLS);
        read_frame(10, 7, 5 * OUT_COLS);
        skip_frames(11, 2);
        clear_counts();
        send_frame(13, 0, 0, 0);
        expect_counts(1, 1, FB_DEPTH);
        read_frame(13, 13, FB_DEPTH);
    endtask

    initial begin
        i_reset = 1'b1;
        i_hsync_n = 1'b1;
        i_vsync_n = 1'b1;
        i_vde = 1'b0;
        i_rgb = '0;
        i_rd_en = 1'b0;
        i_rd_addr = '0;
        test_reset();
        test_capture();
        test_skip();
        test_overflow();
        test_early_vsync();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: frame_capture_top.f
verilog/video_pkg.sv
verilog/capture_pkg.sv
verilog/sync_edge_detect.sv
verilog/pixel_decimator.sv
verilog/frame_buffer.sv
verilog/frame_capture_top.sv
verif/frame_capture_sva.sv
verif/frame_capture_tb.sv

// File: Makefile
TOP := frame_capture_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): frame_capture_top.f verilog/*.sv verif/*.sv
	verilator --binary --timing --assert -Wno-fatal -f frame_capture_top.f \
		--top-module $(TOP) -Mdir $(OBJ)

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f frame_capture_top.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) $(LOG)
